//--- all.f
verilog/ctrl_pkg.sv
verilog/instr_decoder.sv
verilog/phase_sequencer.sv
verilog/ctrl_word_gen.sv
verilog/control_unit.sv
verification/tb_control_unit_asserts.sv
verification/tb_control_unit.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation into sim.log, check the result"
	@echo "  clean  remove build output and the log"
	@echo "  help   list the targets"

test:
	verilator --binary --timing --assert -j 0 --top-module tb_control_unit \
		-f all.f --Mdir obj_dir -o sim_control_unit
	./obj_dir/sim_control_unit > sim.log 2>&1 || true
	@cat sim.log
	@grep -q "^No errors$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- verification/tb_control_unit.sv
`timescale 1ns/1ps

module tb_control_unit;

	logic                 CLK;
	logic                 rst_n;
	ctrl_pkg::instr_t     instruction;
	logic                 zero;
	ctrl_pkg::ctrl_word_t ctrl;
	ctrl_pkg::phase_t     phase;

	int errors   = 0;
	int checks   = 0;
	int timeouts = 0;

	// Expected order of the five phases
	ctrl_pkg::phase_t phase_order [5] = '{ctrl_pkg::PH_FETCH, ctrl_pkg::PH_DECODE,
		ctrl_pkg::PH_EXE, ctrl_pkg::PH_MEM, ctrl_pkg::PH_WB};

	control_unit uut (
		.CLK         (CLK),
		.rst_n       (rst_n),
		.instruction (instruction),
		.zero        (zero),
		.ctrl        (ctrl),
		.phase       (phase)
	);

	// 40 ns clock
	always #20 CLK = ~CLK;

	// ------------------------------------------------------------
	// Instruction builders with random register fields
	// ------------------------------------------------------------
	function automatic ctrl_pkg::instr_t rtype_word(ctrl_pkg::funct_t fn);
		return {ctrl_pkg::OP_RTYPE, 5'($urandom), 5'($urandom), 5'($urandom), 5'($urandom), fn};
	endfunction

	function automatic ctrl_pkg::instr_t itype_word(ctrl_pkg::opcode_t op);
		return {op, 5'($urandom), 5'($urandom), 16'($urandom)};
	endfunction

	function automatic ctrl_pkg::instr_t jtype_word(ctrl_pkg::opcode_t op);
		return {op, 26'($urandom)};
	endfunction

	// ------------------------------------------------------------
	// Reference model of the control rules
	// ------------------------------------------------------------
	function automatic ctrl_pkg::ctrl_word_t ref_ctrl(ctrl_pkg::phase_t ph,
			ctrl_pkg::instr_t ins, logic z);
		ctrl_pkg::opcode_t    op;
		ctrl_pkg::funct_t     fn;
		ctrl_pkg::alu_oprn_t  alu;
		ctrl_pkg::op2_sel_t   op2;
		ctrl_pkg::wa_sel_t    wa;
		ctrl_pkg::wd_sel_t    wd;
		logic                 ld, st, beq, bne, jmp, jr, wr;
		ctrl_pkg::ctrl_word_t c;
		op  = ins[31:26];
		fn  = ins[5:0];
		alu = ctrl_pkg::ALU_NONE;
		op2 = ctrl_pkg::OP2_RT;
		wa  = ctrl_pkg::WA_RD;
		wd  = ctrl_pkg::WD_ALU;
		{ld, st, beq, bne, jmp, jr, wr} = '0;
		case (op)
			ctrl_pkg::OP_RTYPE: begin
				case (fn)
					ctrl_pkg::FN_ADD: alu = ctrl_pkg::ALU_ADD;
					ctrl_pkg::FN_SUB: alu = ctrl_pkg::ALU_SUB;
					ctrl_pkg::FN_MUL: alu = ctrl_pkg::ALU_MUL;
					ctrl_pkg::FN_AND: alu = ctrl_pkg::ALU_AND;
					ctrl_pkg::FN_OR:  alu = ctrl_pkg::ALU_OR;
					ctrl_pkg::FN_NOR: alu = ctrl_pkg::ALU_NOR;
					ctrl_pkg::FN_SLT: alu = ctrl_pkg::ALU_SLT;
					ctrl_pkg::FN_SLL: alu = ctrl_pkg::ALU_SLL;
					ctrl_pkg::FN_SRL: alu = ctrl_pkg::ALU_SRL;
					ctrl_pkg::FN_JR:  jr = 1'b1;
					default: ;
				endcase
				// Every R-type ALU op writes rd
				wr = (alu != ctrl_pkg::ALU_NONE);
				if (fn == ctrl_pkg::FN_SLL || fn == ctrl_pkg::FN_SRL) op2 = ctrl_pkg::OP2_SHAMT;
			end
			ctrl_pkg::OP_ADDI, ctrl_pkg::OP_MULI, ctrl_pkg::OP_SLTI, ctrl_pkg::OP_LUI: begin
				op2 = ctrl_pkg::OP2_SIGN_IMM;
				wr  = 1'b1;
				wa  = ctrl_pkg::WA_RT;
				if (op == ctrl_pkg::OP_ADDI) alu = ctrl_pkg::ALU_ADD;
				if (op == ctrl_pkg::OP_MULI) alu = ctrl_pkg::ALU_MUL;
				if (op == ctrl_pkg::OP_SLTI) alu = ctrl_pkg::ALU_SLT;
				if (op == ctrl_pkg::OP_LUI) wd = ctrl_pkg::WD_UPPER_IMM;
			end
			// Logical immediates are zero extended
			ctrl_pkg::OP_ANDI, ctrl_pkg::OP_ORI: begin
				op2 = ctrl_pkg::OP2_ZERO_IMM;
				wr  = 1'b1;
				wa  = ctrl_pkg::WA_RT;
				alu = (op == ctrl_pkg::OP_ANDI) ? ctrl_pkg::ALU_AND : ctrl_pkg::ALU_OR;
			end
			ctrl_pkg::OP_LW, ctrl_pkg::OP_SW: begin
				alu = ctrl_pkg::ALU_ADD;
				op2 = ctrl_pkg::OP2_SIGN_IMM;
				ld  = (op == ctrl_pkg::OP_LW);
				st  = (op == ctrl_pkg::OP_SW);
				wr  = ld;
				wa  = ctrl_pkg::WA_RT;
				wd  = ctrl_pkg::WD_MEM;
			end
			ctrl_pkg::OP_BEQ: begin
				alu = ctrl_pkg::ALU_SUB;
				beq = 1'b1;
			end
			ctrl_pkg::OP_BNE: begin
				alu = ctrl_pkg::ALU_SUB;
				bne = 1'b1;
			end
			ctrl_pkg::OP_JMP: jmp = 1'b1;
			ctrl_pkg::OP_JAL: begin
				jmp = 1'b1;
				wr  = 1'b1;
				wa  = ctrl_pkg::WA_R31;
				wd  = ctrl_pkg::WD_PC;
			end
			default: ;
		endcase
		// Without a write the selects stay at their first enum values
		if (!wr) begin
			wa = ctrl_pkg::WA_RD;
			wd = ctrl_pkg::WD_ALU;
		end
		c                  = '0;
		c.mem_read         = 1'b1;
		c.mem_addr_from_pc = 1'b1;
		c.reg_read         = 1'b1;
		if (ph != ctrl_pkg::PH_FETCH && ph != ctrl_pkg::PH_DECODE) begin
			c.alu_oprn = alu;
			c.op2_sel  = op2;
		end
		case (ph)
			ctrl_pkg::PH_FETCH: c.ir_load = 1'b1;
			ctrl_pkg::PH_MEM: begin
				if (ld || st) c.mem_addr_from_pc = 1'b0;
				if (st) begin
					c.mem_read  = 1'b0;
					c.mem_write = 1'b1;
				end
			end
			ctrl_pkg::PH_WB: begin
				c.pc_load   = 1'b1;
				c.reg_write = wr;
				c.wa_sel    = wa;
				c.wd_sel    = wd;
				c.reg_read  = jr;
				if (jr) c.pc_src = ctrl_pkg::PC_REG;
				else if (jmp) c.pc_src = ctrl_pkg::PC_JUMP;
				else if ((beq && z) || (bne && !z)) c.pc_src = ctrl_pkg::PC_BRANCH;
				else c.pc_src = ctrl_pkg::PC_INC;
			end
			default: ;
		endcase
		return c;
	endfunction

	// ------------------------------------------------------------
	// Check and instruction run
	// ------------------------------------------------------------
	task automatic check(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("FAILED %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	// One instruction through all five phases with z as the zero flag in WB
	task automatic run_instr(input string name, input ctrl_pkg::instr_t ins, input logic z);
		int               waited;
		ctrl_pkg::phase_t exp_ph;
		logic             zv;
		waited = 0;
		while (phase != ctrl_pkg::PH_FETCH && waited < 20) begin
			@(posedge CLK);
			#1;
			waited++;
		end
		if (phase != ctrl_pkg::PH_FETCH) begin
			timeouts++;
			$display("Timeout: test %s never reached the fetch phase", name);
			return;
		end
		instruction = ins;
		for (int i = 0; i < 5; i++) begin
			if (i > 0) begin
				@(posedge CLK);
				#1;
			end
			// Instruction bus moves on once DECODE has ended
			if (i == 2) instruction = ~ins;
			exp_ph = phase_order[i];
			// Random zero outside WB must not matter
			zv     = (exp_ph == ctrl_pkg::PH_WB) ? z : 1'($urandom_range(1, 0));
			zero   = zv;
			#1;
			check($sformatf("%s phase in %s", name, exp_ph.name()), 32'(exp_ph), 32'(phase));
			check($sformatf("%s ctrl in %s", name, exp_ph.name()),
				32'(ref_ctrl(exp_ph, ins, zv)), 32'(ctrl));
		end
	endtask

	// ------------------------------------------------------------
	// Directed tests
	// ------------------------------------------------------------
	task automatic test_reset_phase_order();
		ctrl_pkg::phase_t exp_ph;
		for (int i = 0; i < 10; i++) begin
			if (i > 0) begin
				@(posedge CLK);
				#1;
			end
			exp_ph = phase_order[i % 5];
			zero   = 1'($urandom_range(1, 0));
			#1;
			check("reset_order phase", 32'(exp_ph), 32'(phase));
			check("reset_order ir_load", 32'(exp_ph == ctrl_pkg::PH_FETCH), 32'(ctrl.ir_load));
			check("reset_order pc_load", 32'(exp_ph == ctrl_pkg::PH_WB), 32'(ctrl.pc_load));
		end
	endtask

	task automatic test_rtype();
		ctrl_pkg::funct_t fns [9] = '{ctrl_pkg::FN_ADD, ctrl_pkg::FN_SUB, ctrl_pkg::FN_MUL,
			ctrl_pkg::FN_AND, ctrl_pkg::FN_OR, ctrl_pkg::FN_NOR, ctrl_pkg::FN_SLT,
			ctrl_pkg::FN_SLL, ctrl_pkg::FN_SRL};
		foreach (fns[i]) run_instr("rtype", rtype_word(fns[i]), 1'($urandom_range(1, 0)));
	endtask

	task automatic test_itype();
		ctrl_pkg::opcode_t ops [6] = '{ctrl_pkg::OP_ADDI, ctrl_pkg::OP_MULI, ctrl_pkg::OP_SLTI,
			ctrl_pkg::OP_ANDI, ctrl_pkg::OP_ORI, ctrl_pkg::OP_LUI};
		foreach (ops[i]) run_instr("itype", itype_word(ops[i]), 1'($urandom_range(1, 0)));
	endtask

	task automatic test_memory();
		run_instr("lw", itype_word(ctrl_pkg::OP_LW), 1'b0);
		run_instr("sw", itype_word(ctrl_pkg::OP_SW), 1'b1);
	endtask

	// Each branch with zero high and low
	task automatic test_branches();
		run_instr("beq_taken", itype_word(ctrl_pkg::OP_BEQ), 1'b1);
		run_instr("beq_not_taken", itype_word(ctrl_pkg::OP_BEQ), 1'b0);
		run_instr("bne_taken", itype_word(ctrl_pkg::OP_BNE), 1'b0);
		run_instr("bne_not_taken", itype_word(ctrl_pkg::OP_BNE), 1'b1);
	endtask

	task automatic test_jumps_unknown();
		run_instr("jmp", jtype_word(ctrl_pkg::OP_JMP), 1'b1);
		run_instr("jal", jtype_word(ctrl_pkg::OP_JAL), 1'b0);
		run_instr("jr", rtype_word(ctrl_pkg::FN_JR), 1'b1);
		run_instr("unknown_opcode", itype_word(6'h3f), 1'b1);
		run_instr("unknown_funct", rtype_word(6'h3f), 1'b0);
	endtask

	initial begin
		void'($urandom(32'hee7acc2c));
		CLK         = 1'b0;
		rst_n       = 1'b0;
		instruction = '0;
		zero        = 1'b0;
		repeat (8) @(posedge CLK);
		#1;
		rst_n = 1'b1;

		test_reset_phase_order();
		test_rtype();
		test_itype();
		test_memory();
		test_branches();
		test_jumps_unknown();

		$display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

//--- verification/tb_control_unit_asserts.sv
`timescale 1ns/1ps

module tb_control_unit_asserts (
	input logic                 CLK,
	input logic                 rst_n,
	input ctrl_pkg::phase_t     phase,
	input ctrl_pkg::ctrl_word_t ctrl
);

	// Successor in the fixed five-phase cycle
	function automatic ctrl_pkg::phase_t succ(ctrl_pkg::phase_t p);
		case (p)
			ctrl_pkg::PH_FETCH:  return ctrl_pkg::PH_DECODE;
			ctrl_pkg::PH_DECODE: return ctrl_pkg::PH_EXE;
			ctrl_pkg::PH_EXE:    return ctrl_pkg::PH_MEM;
			ctrl_pkg::PH_MEM:    return ctrl_pkg::PH_WB;
			default:             return ctrl_pkg::PH_FETCH;
		endcase
	endfunction

	// ------------------------------------------------------------
	// Phase order and bus exclusivity
	// ------------------------------------------------------------
	a_phase_advance: assert property (@(posedge CLK) disable iff (!rst_n)
		1'b1 |=> (phase == succ($past(phase))))
		else $error("Phase did not advance to its successor");

	a_mem_exclusive: assert property (@(posedge CLK) disable iff (!rst_n)
		!(ctrl.mem_read && ctrl.mem_write))
		else $error("Memory read and write high together");

	// State updates only in write-back
	a_wb_only: assert property (@(posedge CLK) disable iff (!rst_n)
		(ctrl.pc_load || ctrl.reg_write) |-> (phase == ctrl_pkg::PH_WB))
		else $error("PC load or register write outside write-back");

endmodule

bind control_unit tb_control_unit_asserts u_asserts (
	.CLK   (CLK),
	.rst_n (rst_n),
	.phase (phase),
	.ctrl  (ctrl)
);

//--- verilog/control_unit.sv
`timescale 1ns/1ps

module control_unit (
	input  logic                 CLK,
	input  logic                 rst_n,
	input  ctrl_pkg::instr_t     instruction,
	input  logic                 zero,
	output ctrl_pkg::ctrl_word_t ctrl,
	output ctrl_pkg::phase_t     phase
);

	// Decoder output and the copy held past DECODE
	ctrl_pkg::decoded_instr_t decoded;
	ctrl_pkg::decoded_instr_t held;

	instr_decoder u_decoder (
		.instruction (instruction),
		.decoded     (decoded)
	);

	phase_sequencer u_sequencer (
		.CLK     (CLK),
		.rst_n   (rst_n),
		.decoded (decoded),
		.phase   (phase),
		.held    (held)
	);

	// Combinational, valid in the same cycle as its phase
	ctrl_word_gen u_ctrl_gen (
		.phase (phase),
		.held  (held),
		.zero  (zero),
		.ctrl  (ctrl)
	);

endmodule

//--- verilog/ctrl_word_gen.sv
`timescale 1ns/1ps

module ctrl_word_gen (
	input  ctrl_pkg::phase_t         phase,
	input  ctrl_pkg::decoded_instr_t held,
	input  logic                     zero,
	output ctrl_pkg::ctrl_word_t     ctrl
);

	logic              branch_taken;
	ctrl_pkg::pc_src_t wb_pc_src;

	// ------------------------------------------------------------
	// Next-PC source for write-back
	// ------------------------------------------------------------
	// beq on equal, bne on not equal
	assign branch_taken = (held.is_branch_eq && zero) || (held.is_branch_ne && !zero);

	always_comb begin
		if (held.is_jr) begin
			wb_pc_src = ctrl_pkg::PC_REG;
		end else if (held.is_jump) begin
			wb_pc_src = ctrl_pkg::PC_JUMP;
		end else if (branch_taken) begin
			wb_pc_src = ctrl_pkg::PC_BRANCH;
		end else begin
			wb_pc_src = ctrl_pkg::PC_INC;
		end
	end

	// ------------------------------------------------------------
	// Control word per phase
	// ------------------------------------------------------------
	always_comb begin
		// Base word, instruction memory addressed by the PC
		ctrl.pc_load          = 1'b0;
		ctrl.pc_src           = ctrl_pkg::PC_INC;
		ctrl.mem_read         = 1'b1;
		ctrl.mem_write        = 1'b0;
		ctrl.mem_addr_from_pc = 1'b1;
		ctrl.ir_load          = 1'b0;
		ctrl.reg_read         = 1'b1;
		ctrl.reg_write        = 1'b0;
		ctrl.wa_sel           = ctrl_pkg::WA_RD;
		ctrl.wd_sel           = ctrl_pkg::WD_ALU;
		ctrl.op2_sel          = ctrl_pkg::OP2_RT;
		ctrl.alu_oprn         = ctrl_pkg::ALU_NONE;

		case (phase)
			// Load the instruction register
			ctrl_pkg::PH_FETCH: begin
				ctrl.ir_load = 1'b1;
			end
			// Register operands read, nothing else changes
			ctrl_pkg::PH_DECODE: ;
			// ALU set up from the held instruction
			ctrl_pkg::PH_EXE: begin
				ctrl.alu_oprn = held.alu_oprn;
				ctrl.op2_sel  = held.op2_sel;
			end
			ctrl_pkg::PH_MEM: begin
				// ALU result stays valid as the data address
				ctrl.alu_oprn = held.alu_oprn;
				ctrl.op2_sel  = held.op2_sel;
				if (held.is_load) begin
					ctrl.mem_addr_from_pc = 1'b0;
				end else if (held.is_store) begin
					ctrl.mem_read         = 1'b0;
					ctrl.mem_write        = 1'b1;
					ctrl.mem_addr_from_pc = 1'b0;
				end
			end
			ctrl_pkg::PH_WB: begin
				ctrl.alu_oprn  = held.alu_oprn;
				ctrl.op2_sel   = held.op2_sel;
				// PC update and register write-back
				ctrl.pc_load   = 1'b1;
				ctrl.pc_src    = wb_pc_src;
				ctrl.reg_write = held.reg_write;
				ctrl.wa_sel    = held.wa_sel;
				ctrl.wd_sel    = held.wd_sel;
				// R[rs] needed only as the jr target
				ctrl.reg_read  = held.is_jr;
			end
			default: ;
		endcase
	end

endmodule

//--- verilog/phase_sequencer.sv
`timescale 1ns/1ps

module phase_sequencer (
	input  logic                     CLK,
	input  logic                     rst_n,
	input  ctrl_pkg::decoded_instr_t decoded,
	output ctrl_pkg::phase_t         phase,
	output ctrl_pkg::decoded_instr_t held
);

	ctrl_pkg::phase_t next_phase;

	// ------------------------------------------------------------
	// Phase order
	// ------------------------------------------------------------
	always_comb begin
		case (phase)
			ctrl_pkg::PH_FETCH:  next_phase = ctrl_pkg::PH_DECODE;
			ctrl_pkg::PH_DECODE: next_phase = ctrl_pkg::PH_EXE;
			ctrl_pkg::PH_EXE:    next_phase = ctrl_pkg::PH_MEM;
			ctrl_pkg::PH_MEM:    next_phase = ctrl_pkg::PH_WB;
			// WB and stray encodings restart at fetch
			default:             next_phase = ctrl_pkg::PH_FETCH;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			phase <= ctrl_pkg::PH_FETCH;
		end else begin
			phase <= next_phase;
		end
	end

	// ------------------------------------------------------------
	// Decoded instruction register
	// ------------------------------------------------------------
	// Captured on the edge that leaves DECODE
	// Held through EXE, MEM, WB and the next FETCH and DECODE
	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			held <= ctrl_pkg::DECODED_NOP;
		end else if (phase == ctrl_pkg::PH_DECODE) begin
			held <= decoded;
		end
	end

endmodule

//--- verilog/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder (
	input  ctrl_pkg::instr_t         instruction,
	output ctrl_pkg::decoded_instr_t decoded
);

	ctrl_pkg::opcode_t opcode;
	ctrl_pkg::funct_t  funct;

	// Field split
	assign opcode = instruction[ctrl_pkg::INSTR_W-1 -: ctrl_pkg::OPCODE_W];
	assign funct  = instruction[ctrl_pkg::FUNCT_W-1:0];

	always_comb begin
		// Anything not listed below stays a no-operation
		decoded = ctrl_pkg::DECODED_NOP;
		case (opcode)
			// ------------------------------------------------------------
			// R-type, rd <= ALU result
			// ------------------------------------------------------------
			ctrl_pkg::OP_RTYPE: begin
				decoded.reg_write = 1'b1;
				case (funct)
					ctrl_pkg::FN_ADD: decoded.alu_oprn = ctrl_pkg::ALU_ADD;
					ctrl_pkg::FN_SUB: decoded.alu_oprn = ctrl_pkg::ALU_SUB;
					ctrl_pkg::FN_MUL: decoded.alu_oprn = ctrl_pkg::ALU_MUL;
					ctrl_pkg::FN_AND: decoded.alu_oprn = ctrl_pkg::ALU_AND;
					ctrl_pkg::FN_OR:  decoded.alu_oprn = ctrl_pkg::ALU_OR;
					ctrl_pkg::FN_NOR: decoded.alu_oprn = ctrl_pkg::ALU_NOR;
					ctrl_pkg::FN_SLT: decoded.alu_oprn = ctrl_pkg::ALU_SLT;
					// Shifts use shamt as operand 2
					ctrl_pkg::FN_SLL: begin
						decoded.alu_oprn = ctrl_pkg::ALU_SLL;
						decoded.op2_sel  = ctrl_pkg::OP2_SHAMT;
					end
					ctrl_pkg::FN_SRL: begin
						decoded.alu_oprn = ctrl_pkg::ALU_SRL;
						decoded.op2_sel  = ctrl_pkg::OP2_SHAMT;
					end
					// PC <= R[rs], no register write
					ctrl_pkg::FN_JR: begin
						decoded.reg_write = 1'b0;
						decoded.is_jr     = 1'b1;
					end
					default: decoded.reg_write = 1'b0;
				endcase
			end
			// ------------------------------------------------------------
			// I-type ALU, rt <= ALU result
			// ------------------------------------------------------------
			ctrl_pkg::OP_ADDI, ctrl_pkg::OP_MULI, ctrl_pkg::OP_SLTI,
			ctrl_pkg::OP_ANDI, ctrl_pkg::OP_ORI: begin
				decoded.reg_write = 1'b1;
				decoded.wa_sel    = ctrl_pkg::WA_RT;
				decoded.op2_sel   = ctrl_pkg::OP2_SIGN_IMM;
				case (opcode)
					ctrl_pkg::OP_ADDI: decoded.alu_oprn = ctrl_pkg::ALU_ADD;
					ctrl_pkg::OP_MULI: decoded.alu_oprn = ctrl_pkg::ALU_MUL;
					ctrl_pkg::OP_SLTI: decoded.alu_oprn = ctrl_pkg::ALU_SLT;
					// Logical immediates are zero extended
					ctrl_pkg::OP_ANDI: begin
						decoded.alu_oprn = ctrl_pkg::ALU_AND;
						decoded.op2_sel  = ctrl_pkg::OP2_ZERO_IMM;
					end
					default: begin
						decoded.alu_oprn = ctrl_pkg::ALU_OR;
						decoded.op2_sel  = ctrl_pkg::OP2_ZERO_IMM;
					end
				endcase
			end
			// rt <= {imm, 16'b0}, ALU idle
			ctrl_pkg::OP_LUI: begin
				decoded.op2_sel   = ctrl_pkg::OP2_SIGN_IMM;
				decoded.reg_write = 1'b1;
				decoded.wa_sel    = ctrl_pkg::WA_RT;
				decoded.wd_sel    = ctrl_pkg::WD_UPPER_IMM;
			end
			// ------------------------------------------------------------
			// Memory, address = R[rs] + sign-extended imm
			// ------------------------------------------------------------
			ctrl_pkg::OP_LW: begin
				decoded.alu_oprn  = ctrl_pkg::ALU_ADD;
				decoded.op2_sel   = ctrl_pkg::OP2_SIGN_IMM;
				decoded.is_load   = 1'b1;
				decoded.reg_write = 1'b1;
				decoded.wa_sel    = ctrl_pkg::WA_RT;
				decoded.wd_sel    = ctrl_pkg::WD_MEM;
			end
			ctrl_pkg::OP_SW: begin
				decoded.alu_oprn = ctrl_pkg::ALU_ADD;
				decoded.op2_sel  = ctrl_pkg::OP2_SIGN_IMM;
				decoded.is_store = 1'b1;
			end
			// Branches compare R[rs] - R[rt] through the zero flag
			ctrl_pkg::OP_BEQ: begin
				decoded.alu_oprn     = ctrl_pkg::ALU_SUB;
				decoded.is_branch_eq = 1'b1;
			end
			ctrl_pkg::OP_BNE: begin
				decoded.alu_oprn     = ctrl_pkg::ALU_SUB;
				decoded.is_branch_ne = 1'b1;
			end
			// Jumps
			ctrl_pkg::OP_JMP: decoded.is_jump = 1'b1;
			ctrl_pkg::OP_JAL: begin
				decoded.is_jump   = 1'b1;
				decoded.reg_write = 1'b1;
				decoded.wa_sel    = ctrl_pkg::WA_R31;
				decoded.wd_sel    = ctrl_pkg::WD_PC;
			end
			default: ;
		endcase
	end

endmodule

//--- verilog/ctrl_pkg.sv
package ctrl_pkg;

	// ------------------------------------------------------------
	// Instruction fields
	// ------------------------------------------------------------
	localparam int INSTR_W  = 32;
	localparam int OPCODE_W = 6;
	localparam int FUNCT_W  = 6;

	typedef logic [INSTR_W-1:0]  instr_t;
	typedef logic [OPCODE_W-1:0] opcode_t;
	typedef logic [FUNCT_W-1:0]  funct_t;

	// Opcodes
	localparam opcode_t OP_RTYPE = 6'h00;
	localparam opcode_t OP_ADDI  = 6'h08;
	localparam opcode_t OP_MULI  = 6'h1d;
	localparam opcode_t OP_ANDI  = 6'h0c;
	localparam opcode_t OP_ORI   = 6'h0d;
	localparam opcode_t OP_LUI   = 6'h0f;
	localparam opcode_t OP_SLTI  = 6'h0a;
	localparam opcode_t OP_BEQ   = 6'h04;
	localparam opcode_t OP_BNE   = 6'h05;
	localparam opcode_t OP_LW    = 6'h23;
	localparam opcode_t OP_SW    = 6'h2b;
	localparam opcode_t OP_JMP   = 6'h02;
	localparam opcode_t OP_JAL   = 6'h03;

	// R-type funct codes
	localparam funct_t FN_ADD = 6'h20;
	localparam funct_t FN_SUB = 6'h22;
	localparam funct_t FN_MUL = 6'h2c;
	localparam funct_t FN_AND = 6'h24;
	localparam funct_t FN_OR  = 6'h25;
	localparam funct_t FN_NOR = 6'h27;
	localparam funct_t FN_SLT = 6'h2a;
	localparam funct_t FN_SLL = 6'h00;
	localparam funct_t FN_SRL = 6'h02;
	localparam funct_t FN_JR  = 6'h08;

	// ------------------------------------------------------------
	// Control encodings
	// ------------------------------------------------------------
	typedef enum logic [2:0] {
		PH_FETCH  = 3'd0,
		PH_DECODE = 3'd1,
		PH_EXE    = 3'd2,
		PH_MEM    = 3'd3,
		PH_WB     = 3'd4
	} phase_t;

	// ALU operation codes as the datapath ALU expects them
	typedef enum logic [4:0] {
		ALU_NONE = 5'd0,
		ALU_ADD  = 5'd1,
		ALU_SUB  = 5'd2,
		ALU_MUL  = 5'd3,
		ALU_SRL  = 5'd4,
		ALU_SLL  = 5'd5,
		ALU_AND  = 5'd6,
		ALU_OR   = 5'd7,
		ALU_NOR  = 5'd8,
		ALU_SLT  = 5'd9
	} alu_oprn_t;

	// ALU operand 2 source
	typedef enum logic [1:0] {
		OP2_RT       = 2'd0,
		OP2_SHAMT    = 2'd1,
		OP2_SIGN_IMM = 2'd2,
		OP2_ZERO_IMM = 2'd3
	} op2_sel_t;

	typedef enum logic [1:0] {
		PC_INC    = 2'd0,
		PC_BRANCH = 2'd1,
		PC_JUMP   = 2'd2,
		PC_REG    = 2'd3
	} pc_src_t;

	// Register file write address
	typedef enum logic [1:0] {
		WA_RD  = 2'd0,
		WA_RT  = 2'd1,
		WA_R31 = 2'd2
	} wa_sel_t;

	// Register file write data
	typedef enum logic [1:0] {
		WD_ALU       = 2'd0,
		WD_MEM       = 2'd1,
		WD_UPPER_IMM = 2'd2,
		WD_PC        = 2'd3
	} wd_sel_t;

	// ------------------------------------------------------------
	// Structs
	// ------------------------------------------------------------
	typedef struct packed {
		alu_oprn_t alu_oprn;
		op2_sel_t  op2_sel;
		logic      is_load;
		logic      is_store;
		logic      is_branch_eq;
		logic      is_branch_ne;
		logic      is_jump;
		logic      is_jr;
		logic      reg_write;
		wa_sel_t   wa_sel;
		wd_sel_t   wd_sel;
	} decoded_instr_t;

	typedef struct packed {
		logic      pc_load;
		pc_src_t   pc_src;
		logic      mem_read;
		logic      mem_write;
		logic      mem_addr_from_pc;
		logic      ir_load;
		logic      reg_read;
		logic      reg_write;
		wa_sel_t   wa_sel;
		wd_sel_t   wd_sel;
		op2_sel_t  op2_sel;
		alu_oprn_t alu_oprn;
	} ctrl_word_t;

	// No-operation, PC still advances in write-back
	localparam decoded_instr_t DECODED_NOP = '{
		alu_oprn:     ALU_NONE,
		op2_sel:      OP2_RT,
		is_load:      1'b0,
		is_store:     1'b0,
		is_branch_eq: 1'b0,
		is_branch_ne: 1'b0,
		is_jump:      1'b0,
		is_jr:        1'b0,
		reg_write:    1'b0,
		wa_sel:       WA_RD,
		wd_sel:       WD_ALU
	};

endpackage
